//--- verilog/i2c_periph_params.svh
// register offsets, reset defaults and FIFO sizing for the I2C peripheral bridge
`ifndef I2C_PERIPH_PARAMS_SVH
`define I2C_PERIPH_PARAMS_SVH

// I2C engine configuration, written by APB only
`define REG_DEV_ADDR        8'h00
`define REG_ENABLE          8'h01
`define REG_DEBOUNCE        8'h02
`define REG_SCL_DLY         8'h03
`define REG_SDA_DLY         8'h04

`define REG_MSG_TOAPB       8'h10
`define REG_MSG_TOAPB_ST    8'h11
`define REG_MSG_TOI2C       8'h12
`define REG_MSG_TOI2C_ST    8'h13

`define REG_FIFO_TOAPB_WR   8'h20
`define REG_FIFO_TOAPB_RD   8'h21
`define REG_FIFO_TOAPB_WFLG 8'h23
`define REG_FIFO_TOAPB_RFLG 8'h24
`define REG_FIFO_TOI2C_WR   8'h30
`define REG_FIFO_TOI2C_RD   8'h31
`define REG_FIFO_TOI2C_WFLG 8'h33
`define REG_FIFO_TOI2C_RFLG 8'h34

// status +0, enable +1, select a +2, select b +3
`define REG_IRQ_I2C_BASE    8'h40
`define REG_IRQ_APB_BASE    8'h50

`define DEF_DEV_ADDR        7'h6F
`define DEF_DEBOUNCE        8'd20
`define DEF_SCL_DLY         8'd20
`define DEF_SDA_DLY         8'd8

`define FIFO_DEPTH          16
`define FIFO_PTR_W          4

`endif

//--- verilog/i2c_periph_pkg.sv
// vector types and mailbox state encoding shared by the I2C peripheral bridge
package i2c_periph_pkg;

  typedef logic [7:0]  byte_t;      // data byte or register value
  typedef logic [7:0]  reg_idx_t;   // register index, same on both hosts
  typedef logic [11:0] apb_addr_t;  // APB byte address
  typedef logic [6:0]  dev_addr_t;  // 7-bit I2C device address
  typedef logic [2:0]  fifo_flag_t; // FIFO level code
  typedef logic [2:0]  irq_vec_t;   // {flag a, flag b, mailbox}

  // single-byte mailbox occupancy
  typedef enum logic {
    MBOX_EMPTY,
    MBOX_PENDING
  } mbox_state_t;

endpackage

//--- verilog/byte_fifo.sv
// synchronous show-ahead byte FIFO with fill count and write/read level codes
`include "i2c_periph_params.svh"

module byte_fifo import i2c_periph_pkg::*; (
  input  logic       rst_i,
  input  logic       clk_i,
  input  logic       push_i,
  input  byte_t      wdata_i,
  input  logic       pop_i,
  output byte_t      head_o,
  output fifo_flag_t wr_flags_o,
  output fifo_flag_t rd_flags_o,
  output logic       full_o,
  output logic       empty_o
);

  byte_t                  mem [`FIFO_DEPTH];
  logic [`FIFO_PTR_W-1:0] wr_ptr;
  logic [`FIFO_PTR_W-1:0] rd_ptr;
  logic [`FIFO_PTR_W:0]   count;
  logic                   do_push;
  logic                   do_pop;

  assign full_o  = (count == (`FIFO_PTR_W+1)'(`FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o; // overflow byte is dropped
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem[rd_ptr];       // show-ahead

  always_ff @(posedge rst_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // level code from fill count
  always_comb begin
    if (count == 5'd0) rd_flags_o = 3'd0;
    else if (count == 5'd1) rd_flags_o = 3'd1;
    else if (count < 5'd4) rd_flags_o = 3'd2;
    else if (count < 5'd8) rd_flags_o = 3'd3;
    else if (count < 5'd12) rd_flags_o = 3'd4;
    else if (count < 5'd15) rd_flags_o = 3'd5;
    else if (count == 5'd15) rd_flags_o = 3'd6;
    else rd_flags_o = 3'd7;
  end

  assign wr_flags_o = 3'd7 - rd_flags_o; // write side sees the mirror code

  a_count_bound: assert property (@(posedge rst_i) disable iff (clk_i)
    count <= (`FIFO_PTR_W+1)'(`FIFO_DEPTH));

endmodule

//--- verilog/msg_mailbox.sv
// single-byte message register with pending flag state machine
module msg_mailbox import i2c_periph_pkg::*; (
  input  logic  rst_i,
  input  logic  clk_i,
  input  logic  wr_i,
  input  byte_t wdata_i,
  input  logic  rd_done_i,
  output byte_t data_o,
  output logic  pending_o
);

  mbox_state_t state;

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      state  <= MBOX_EMPTY;
      data_o <= '0;
    end else begin
      if (wr_i) data_o <= wdata_i; // every write replaces the byte
      case (state)
        MBOX_EMPTY: begin
          if (wr_i) state <= MBOX_PENDING;
        end
        MBOX_PENDING: begin
          // a fresh write beats a read completing in the same cycle
          if (rd_done_i && !wr_i) state <= MBOX_EMPTY;
        end
        default: state <= MBOX_EMPTY;
      endcase
    end
  end

  assign pending_o = (state == MBOX_PENDING);

endmodule

//--- verilog/irq_gen.sv
// interrupt enable and flag select registers, status vector and line for one host
module irq_gen import i2c_periph_pkg::*; (
  input  logic       rst_i,
  input  logic       clk_i,
  input  logic       cfg_wr_i,
  input  logic [1:0] cfg_idx_i,   // offset inside the irq block
  input  byte_t      cfg_data_i,
  input  fifo_flag_t flag_a_i,
  input  fifo_flag_t flag_b_i,
  input  logic       msg_pend_i,
  output irq_vec_t   enable_o,
  output byte_t      sel_a_o,
  output byte_t      sel_b_o,
  output irq_vec_t   status_o,
  output logic       irq_o
);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      enable_o <= '0;
      sel_a_o  <= '0;
      sel_b_o  <= '0;
    end else if (cfg_wr_i) begin
      case (cfg_idx_i)
        2'd1:    enable_o <= cfg_data_i[2:0];
        2'd2:    sel_a_o  <= cfg_data_i;
        2'd3:    sel_b_o  <= cfg_data_i;
        default: ; // status is read only
      endcase
    end
  end

  // each select bit picks one level code
  assign status_o[2] = enable_o[2] && sel_a_o[flag_a_i];
  assign status_o[1] = enable_o[1] && sel_b_o[flag_b_i];
  assign status_o[0] = enable_o[0] && msg_pend_i;
  assign irq_o       = |status_o;

  // status sits at offset 0 and takes no writes
  a_cfg_idx_writable: assert property (@(posedge rst_i) disable iff (clk_i)
    cfg_wr_i |-> (cfg_idx_i != 2'd0));

endmodule

//--- verilog/apb_reg_port.sv
// APB register port: configuration registers, write and read decode, strobes, read mux
`include "i2c_periph_params.svh"

module apb_reg_port import i2c_periph_pkg::*; (
  input  logic        rst_i,
  input  logic        clk_i,
  input  apb_addr_t   apb_waddr_i,
  input  logic [31:0] apb_wdata_i,
  input  logic        apb_wr_en_i,
  input  apb_addr_t   apb_raddr_i,
  input  logic        apb_rd_done_i,
  input  byte_t       msg_toapb_i,
  input  logic        msg_toapb_pend_i,
  input  byte_t       msg_toi2c_i,
  input  logic        msg_toi2c_pend_i,
  input  byte_t       fifo_toapb_head_i,
  input  fifo_flag_t  fifo_toapb_wflg_i,
  input  fifo_flag_t  fifo_toapb_rflg_i,
  input  fifo_flag_t  fifo_toi2c_wflg_i,
  input  fifo_flag_t  fifo_toi2c_rflg_i,
  input  irq_vec_t    i2c_irq_status_i,
  input  irq_vec_t    i2c_irq_enable_i,
  input  byte_t       i2c_irq_sel_a_i,
  input  byte_t       i2c_irq_sel_b_i,
  input  irq_vec_t    apb_irq_status_i,
  input  irq_vec_t    apb_irq_enable_i,
  input  byte_t       apb_irq_sel_a_i,
  input  byte_t       apb_irq_sel_b_i,
  output dev_addr_t   dev_addr_o,
  output logic        enable_o,
  output byte_t       debounce_len_o,
  output byte_t       scl_dly_o,
  output byte_t       sda_dly_o,
  output logic        msg_wr_o,
  output logic        fifo_push_o,
  output byte_t       fifo_wdata_o,
  output logic        fifo_pop_o,
  output logic        msg_rd_done_o,
  output logic        irq_cfg_wr_o,
  output logic [1:0]  irq_cfg_idx_o,
  output byte_t       irq_cfg_data_o,
  output logic [31:0] apb_rdata_o
);

  reg_idx_t wr_idx;
  reg_idx_t rd_idx;
  logic     wr_ok;
  logic     rd_ok;
  logic     rd_done_ok;
  byte_t    wr_byte;
  byte_t    rd_mux;

  // registers sit on word addresses and the upper window is unmapped
  assign wr_ok      = apb_wr_en_i && (apb_waddr_i[11:10] == 2'b00);
  assign wr_idx     = apb_waddr_i[9:2];
  assign rd_ok      = (apb_raddr_i[11:10] == 2'b00);
  assign rd_idx     = apb_raddr_i[9:2];
  assign rd_done_ok = apb_rd_done_i && rd_ok;

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      dev_addr_o     <= `DEF_DEV_ADDR;
      enable_o       <= 1'b0;
      debounce_len_o <= `DEF_DEBOUNCE;
      scl_dly_o      <= `DEF_SCL_DLY;
      sda_dly_o      <= `DEF_SDA_DLY;
    end else if (wr_ok) begin
      case (wr_idx)
        `REG_DEV_ADDR: dev_addr_o     <= apb_wdata_i[6:0];
        `REG_ENABLE:   enable_o       <= apb_wdata_i[0];
        `REG_DEBOUNCE: debounce_len_o <= apb_wdata_i[7:0];
        `REG_SCL_DLY:  scl_dly_o      <= apb_wdata_i[7:0];
        `REG_SDA_DLY:  sda_dly_o      <= apb_wdata_i[7:0];
        default:       ;
      endcase
    end
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      msg_wr_o      <= 1'b0;
      fifo_push_o   <= 1'b0;
      irq_cfg_wr_o  <= 1'b0;
      fifo_pop_o    <= 1'b0;
      msg_rd_done_o <= 1'b0;
      apb_rdata_o   <= '0;
    end else begin
      msg_wr_o      <= wr_ok && (wr_idx == `REG_MSG_TOI2C);
      fifo_push_o   <= wr_ok && (wr_idx == `REG_FIFO_TOI2C_WR);
      irq_cfg_wr_o  <= wr_ok && ((wr_idx & 8'hFC) == `REG_IRQ_APB_BASE) && (wr_idx[1:0] != 2'd0);
      fifo_pop_o    <= rd_done_ok && (rd_idx == `REG_FIFO_TOAPB_RD);
      msg_rd_done_o <= rd_done_ok && (rd_idx == `REG_MSG_TOAPB);
      apb_rdata_o   <= {24'h0, rd_mux};
    end
  end

  // write byte and irq offset travel with the strobes
  always_ff @(posedge rst_i) begin
    if (wr_ok) begin
      wr_byte       <= apb_wdata_i[7:0];
      irq_cfg_idx_o <= wr_idx[1:0];
    end
  end

  assign fifo_wdata_o   = wr_byte; // also the mailbox data byte
  assign irq_cfg_data_o = wr_byte;

  always_comb begin
    rd_mux = 8'h00;
    if (rd_ok) begin
      case (rd_idx)
        `REG_DEV_ADDR:            rd_mux = {1'b0, dev_addr_o};
        `REG_ENABLE:              rd_mux = {7'b0, enable_o};
        `REG_DEBOUNCE:            rd_mux = debounce_len_o;
        `REG_SCL_DLY:             rd_mux = scl_dly_o;
        `REG_SDA_DLY:             rd_mux = sda_dly_o;
        `REG_MSG_TOAPB:           rd_mux = msg_toapb_i;
        `REG_MSG_TOAPB_ST:        rd_mux = {7'b0, msg_toapb_pend_i};
        `REG_MSG_TOI2C:           rd_mux = msg_toi2c_i;
        `REG_MSG_TOI2C_ST:        rd_mux = {7'b0, msg_toi2c_pend_i};
        `REG_FIFO_TOAPB_RD:       rd_mux = fifo_toapb_head_i;
        `REG_FIFO_TOAPB_WFLG:     rd_mux = {5'b0, fifo_toapb_wflg_i};
        `REG_FIFO_TOAPB_RFLG:     rd_mux = {5'b0, fifo_toapb_rflg_i};
        `REG_FIFO_TOI2C_WFLG:     rd_mux = {5'b0, fifo_toi2c_wflg_i};
        `REG_FIFO_TOI2C_RFLG:     rd_mux = {5'b0, fifo_toi2c_rflg_i};
        `REG_IRQ_I2C_BASE:        rd_mux = {5'b0, i2c_irq_status_i};
        `REG_IRQ_I2C_BASE + 8'd1: rd_mux = {5'b0, i2c_irq_enable_i};
        `REG_IRQ_I2C_BASE + 8'd2: rd_mux = i2c_irq_sel_a_i;
        `REG_IRQ_I2C_BASE + 8'd3: rd_mux = i2c_irq_sel_b_i;
        `REG_IRQ_APB_BASE:        rd_mux = {5'b0, apb_irq_status_i};
        `REG_IRQ_APB_BASE + 8'd1: rd_mux = {5'b0, apb_irq_enable_i};
        `REG_IRQ_APB_BASE + 8'd2: rd_mux = apb_irq_sel_a_i;
        `REG_IRQ_APB_BASE + 8'd3: rd_mux = apb_irq_sel_b_i;
        default:                  rd_mux = 8'h00; // write-only data ports read zero
      endcase
    end
  end

  // fifo_wdata_o feeds both the mailbox and the FIFO so only one strobe fires at a time
  a_push_msg_excl: assert property (@(posedge rst_i) disable iff (clk_i)
    !(fifo_push_o && msg_wr_o));

endmodule

//--- verilog/i2c_reg_port.sv
// I2C register port: address decode, registered strobes and registered read mux
`include "i2c_periph_params.svh"

module i2c_reg_port import i2c_periph_pkg::*; (
  input  logic       rst_i,
  input  logic       clk_i,
  input  reg_idx_t   i2c_addr_i,
  input  byte_t      i2c_wdata_i,
  input  logic       i2c_wr_en_i,
  input  logic       i2c_rd_done_i,
  input  dev_addr_t  dev_addr_i,
  input  logic       enable_i,
  input  byte_t      debounce_len_i,
  input  byte_t      scl_dly_i,
  input  byte_t      sda_dly_i,
  input  byte_t      msg_toapb_i,
  input  logic       msg_toapb_pend_i,
  input  byte_t      msg_toi2c_i,
  input  logic       msg_toi2c_pend_i,
  input  byte_t      fifo_toi2c_head_i,
  input  fifo_flag_t fifo_toapb_wflg_i,
  input  fifo_flag_t fifo_toapb_rflg_i,
  input  fifo_flag_t fifo_toi2c_wflg_i,
  input  fifo_flag_t fifo_toi2c_rflg_i,
  input  irq_vec_t   i2c_irq_status_i,
  input  irq_vec_t   i2c_irq_enable_i,
  input  byte_t      i2c_irq_sel_a_i,
  input  byte_t      i2c_irq_sel_b_i,
  input  irq_vec_t   apb_irq_status_i,
  input  irq_vec_t   apb_irq_enable_i,
  input  byte_t      apb_irq_sel_a_i,
  input  byte_t      apb_irq_sel_b_i,
  output logic       msg_wr_o,
  output logic       fifo_push_o,
  output byte_t      fifo_wdata_o,
  output logic       fifo_pop_o,
  output logic       msg_rd_done_o,
  output logic       irq_cfg_wr_o,
  output logic [1:0] irq_cfg_idx_o,
  output byte_t      irq_cfg_data_o,
  output byte_t      i2c_rdata_o
);

  byte_t wr_byte;
  byte_t rd_mux;

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      msg_wr_o      <= 1'b0;
      fifo_push_o   <= 1'b0;
      irq_cfg_wr_o  <= 1'b0;
      fifo_pop_o    <= 1'b0;
      msg_rd_done_o <= 1'b0;
      i2c_rdata_o   <= '0;
    end else begin
      msg_wr_o      <= i2c_wr_en_i && (i2c_addr_i == `REG_MSG_TOAPB);
      fifo_push_o   <= i2c_wr_en_i && (i2c_addr_i == `REG_FIFO_TOAPB_WR);
      irq_cfg_wr_o  <= i2c_wr_en_i && ((i2c_addr_i & 8'hFC) == `REG_IRQ_I2C_BASE)
                       && (i2c_addr_i[1:0] != 2'd0);
      fifo_pop_o    <= i2c_rd_done_i && (i2c_addr_i == `REG_FIFO_TOI2C_RD);
      msg_rd_done_o <= i2c_rd_done_i && (i2c_addr_i == `REG_MSG_TOI2C);
      i2c_rdata_o   <= rd_mux;
    end
  end

  always_ff @(posedge rst_i) begin
    if (i2c_wr_en_i) begin
      wr_byte       <= i2c_wdata_i;
      irq_cfg_idx_o <= i2c_addr_i[1:0];
    end
  end

  assign fifo_wdata_o   = wr_byte;
  assign irq_cfg_data_o = wr_byte;

  // no window gate on this side, unmapped reads give zero
  always_comb begin
    case (i2c_addr_i)
      `REG_DEV_ADDR:            rd_mux = {1'b0, dev_addr_i};
      `REG_ENABLE:              rd_mux = {7'b0, enable_i};
      `REG_DEBOUNCE:            rd_mux = debounce_len_i;
      `REG_SCL_DLY:             rd_mux = scl_dly_i;
      `REG_SDA_DLY:             rd_mux = sda_dly_i;
      `REG_MSG_TOAPB:           rd_mux = msg_toapb_i;
      `REG_MSG_TOAPB_ST:        rd_mux = {7'b0, msg_toapb_pend_i};
      `REG_MSG_TOI2C:           rd_mux = msg_toi2c_i;
      `REG_MSG_TOI2C_ST:        rd_mux = {7'b0, msg_toi2c_pend_i};
      `REG_FIFO_TOI2C_RD:       rd_mux = fifo_toi2c_head_i;
      `REG_FIFO_TOAPB_WFLG:     rd_mux = {5'b0, fifo_toapb_wflg_i};
      `REG_FIFO_TOAPB_RFLG:     rd_mux = {5'b0, fifo_toapb_rflg_i};
      `REG_FIFO_TOI2C_WFLG:     rd_mux = {5'b0, fifo_toi2c_wflg_i};
      `REG_FIFO_TOI2C_RFLG:     rd_mux = {5'b0, fifo_toi2c_rflg_i};
      `REG_IRQ_I2C_BASE:        rd_mux = {5'b0, i2c_irq_status_i};
      `REG_IRQ_I2C_BASE + 8'd1: rd_mux = {5'b0, i2c_irq_enable_i};
      `REG_IRQ_I2C_BASE + 8'd2: rd_mux = i2c_irq_sel_a_i;
      `REG_IRQ_I2C_BASE + 8'd3: rd_mux = i2c_irq_sel_b_i;
      `REG_IRQ_APB_BASE:        rd_mux = {5'b0, apb_irq_status_i};
      `REG_IRQ_APB_BASE + 8'd1: rd_mux = {5'b0, apb_irq_enable_i};
      `REG_IRQ_APB_BASE + 8'd2: rd_mux = apb_irq_sel_a_i;
      `REG_IRQ_APB_BASE + 8'd3: rd_mux = apb_irq_sel_b_i;
      default:                  rd_mux = 8'h00;
    endcase
  end

endmodule

//--- verilog/i2c_periph_top.sv
// top level: APB and I2C register ports, mailboxes, FIFOs and interrupt blocks
module i2c_periph_top import i2c_periph_pkg::*; (
  input  logic        rst_i,
  input  logic        clk_i,
  input  apb_addr_t   apb_waddr_i,
  input  logic [31:0] apb_wdata_i,
  input  logic        apb_wr_en_i,
  input  apb_addr_t   apb_raddr_i,
  input  logic        apb_rd_done_i,
  input  reg_idx_t    i2c_addr_i,
  input  byte_t       i2c_wdata_i,
  input  logic        i2c_wr_en_i,
  input  logic        i2c_rd_done_i,
  output logic [31:0] apb_rdata_o,
  output byte_t       i2c_rdata_o,
  output dev_addr_t   dev_addr_o,
  output logic        enable_o,
  output byte_t       debounce_len_o,
  output byte_t       scl_dly_o,
  output byte_t       sda_dly_o,
  output logic        i2c_irq_o,
  output logic        apb_irq_o
);

  // strobes out of each port
  logic       apb_msg_wr, apb_push, apb_pop, apb_msg_rd_done, apb_cfg_wr;
  logic       i2c_msg_wr, i2c_push, i2c_pop, i2c_msg_rd_done, i2c_cfg_wr;
  logic [1:0] apb_cfg_idx, i2c_cfg_idx;
  byte_t      apb_wbyte, apb_cfg_data, i2c_wbyte, i2c_cfg_data;

  // mailbox and FIFO state
  byte_t      toapb_msg, toi2c_msg, toapb_head, toi2c_head;
  logic       toapb_pend, toi2c_pend;
  fifo_flag_t toapb_wflg, toapb_rflg, toi2c_wflg, toi2c_rflg;

  // interrupt block registers
  irq_vec_t   i2c_irq_status, i2c_irq_en, apb_irq_status, apb_irq_en;
  byte_t      i2c_irq_sel_a, i2c_irq_sel_b, apb_irq_sel_a, apb_irq_sel_b;

  apb_reg_port u_apb_port (
    .rst_i(rst_i), .clk_i(clk_i),
    .apb_waddr_i(apb_waddr_i), .apb_wdata_i(apb_wdata_i), .apb_wr_en_i(apb_wr_en_i),
    .apb_raddr_i(apb_raddr_i), .apb_rd_done_i(apb_rd_done_i),
    .msg_toapb_i(toapb_msg), .msg_toapb_pend_i(toapb_pend),
    .msg_toi2c_i(toi2c_msg), .msg_toi2c_pend_i(toi2c_pend),
    .fifo_toapb_head_i(toapb_head),
    .fifo_toapb_wflg_i(toapb_wflg), .fifo_toapb_rflg_i(toapb_rflg),
    .fifo_toi2c_wflg_i(toi2c_wflg), .fifo_toi2c_rflg_i(toi2c_rflg),
    .i2c_irq_status_i(i2c_irq_status), .i2c_irq_enable_i(i2c_irq_en),
    .i2c_irq_sel_a_i(i2c_irq_sel_a), .i2c_irq_sel_b_i(i2c_irq_sel_b),
    .apb_irq_status_i(apb_irq_status), .apb_irq_enable_i(apb_irq_en),
    .apb_irq_sel_a_i(apb_irq_sel_a), .apb_irq_sel_b_i(apb_irq_sel_b),
    .dev_addr_o(dev_addr_o), .enable_o(enable_o), .debounce_len_o(debounce_len_o),
    .scl_dly_o(scl_dly_o), .sda_dly_o(sda_dly_o),
    .msg_wr_o(apb_msg_wr), .fifo_push_o(apb_push), .fifo_wdata_o(apb_wbyte),
    .fifo_pop_o(apb_pop), .msg_rd_done_o(apb_msg_rd_done),
    .irq_cfg_wr_o(apb_cfg_wr), .irq_cfg_idx_o(apb_cfg_idx), .irq_cfg_data_o(apb_cfg_data),
    .apb_rdata_o(apb_rdata_o)
  );

  i2c_reg_port u_i2c_port (
    .rst_i(rst_i), .clk_i(clk_i),
    .i2c_addr_i(i2c_addr_i), .i2c_wdata_i(i2c_wdata_i), .i2c_wr_en_i(i2c_wr_en_i),
    .i2c_rd_done_i(i2c_rd_done_i),
    .dev_addr_i(dev_addr_o), .enable_i(enable_o), .debounce_len_i(debounce_len_o),
    .scl_dly_i(scl_dly_o), .sda_dly_i(sda_dly_o),
    .msg_toapb_i(toapb_msg), .msg_toapb_pend_i(toapb_pend),
    .msg_toi2c_i(toi2c_msg), .msg_toi2c_pend_i(toi2c_pend),
    .fifo_toi2c_head_i(toi2c_head),
    .fifo_toapb_wflg_i(toapb_wflg), .fifo_toapb_rflg_i(toapb_rflg),
    .fifo_toi2c_wflg_i(toi2c_wflg), .fifo_toi2c_rflg_i(toi2c_rflg),
    .i2c_irq_status_i(i2c_irq_status), .i2c_irq_enable_i(i2c_irq_en),
    .i2c_irq_sel_a_i(i2c_irq_sel_a), .i2c_irq_sel_b_i(i2c_irq_sel_b),
    .apb_irq_status_i(apb_irq_status), .apb_irq_enable_i(apb_irq_en),
    .apb_irq_sel_a_i(apb_irq_sel_a), .apb_irq_sel_b_i(apb_irq_sel_b),
    .msg_wr_o(i2c_msg_wr), .fifo_push_o(i2c_push), .fifo_wdata_o(i2c_wbyte),
    .fifo_pop_o(i2c_pop), .msg_rd_done_o(i2c_msg_rd_done),
    .irq_cfg_wr_o(i2c_cfg_wr), .irq_cfg_idx_o(i2c_cfg_idx), .irq_cfg_data_o(i2c_cfg_data),
    .i2c_rdata_o(i2c_rdata_o)
  );

  // written by I2C, drained by APB
  msg_mailbox u_mbox_toapb (
    .rst_i(rst_i), .clk_i(clk_i), .wr_i(i2c_msg_wr), .wdata_i(i2c_wbyte),
    .rd_done_i(apb_msg_rd_done), .data_o(toapb_msg), .pending_o(toapb_pend)
  );

  msg_mailbox u_mbox_toi2c (
    .rst_i(rst_i), .clk_i(clk_i), .wr_i(apb_msg_wr), .wdata_i(apb_wbyte),
    .rd_done_i(i2c_msg_rd_done), .data_o(toi2c_msg), .pending_o(toi2c_pend)
  );

  byte_fifo u_fifo_toapb (
    .rst_i(rst_i), .clk_i(clk_i), .push_i(i2c_push), .wdata_i(i2c_wbyte),
    .pop_i(apb_pop), .head_o(toapb_head), .wr_flags_o(toapb_wflg),
    .rd_flags_o(toapb_rflg), .full_o(), .empty_o()
  );

  byte_fifo u_fifo_toi2c (
    .rst_i(rst_i), .clk_i(clk_i), .push_i(apb_push), .wdata_i(apb_wbyte),
    .pop_i(i2c_pop), .head_o(toi2c_head), .wr_flags_o(toi2c_wflg),
    .rd_flags_o(toi2c_rflg), .full_o(), .empty_o()
  );

  // I2C host watches room in its outgoing FIFO and data in its incoming one
  irq_gen u_irq_i2c (
    .rst_i(rst_i), .clk_i(clk_i),
    .cfg_wr_i(i2c_cfg_wr), .cfg_idx_i(i2c_cfg_idx), .cfg_data_i(i2c_cfg_data),
    .flag_a_i(toapb_wflg), .flag_b_i(toi2c_rflg), .msg_pend_i(toi2c_pend),
    .enable_o(i2c_irq_en), .sel_a_o(i2c_irq_sel_a), .sel_b_o(i2c_irq_sel_b),
    .status_o(i2c_irq_status), .irq_o(i2c_irq_o)
  );

  irq_gen u_irq_apb (
    .rst_i(rst_i), .clk_i(clk_i),
    .cfg_wr_i(apb_cfg_wr), .cfg_idx_i(apb_cfg_idx), .cfg_data_i(apb_cfg_data),
    .flag_a_i(toi2c_wflg), .flag_b_i(toapb_rflg), .msg_pend_i(toapb_pend),
    .enable_o(apb_irq_en), .sel_a_o(apb_irq_sel_a), .sel_b_o(apb_irq_sel_b),
    .status_o(apb_irq_status), .irq_o(apb_irq_o)
  );

endmodule

//--- verif/tb_i2c_periph.sv
// testbench for the I2C peripheral bridge: stimulus tasks, immediate and concurrent checks
`include "i2c_periph_params.svh"

module tb_i2c_periph;
  timeunit 1ns;
  timeprecision 100ps;

  logic        rst;  // clock
  logic        clk;  // async reset, active high
  logic [11:0] apb_waddr;
  logic [31:0] apb_wdata;
  logic        apb_wr_en;
  logic [11:0] apb_raddr;
  logic        apb_rd_done;
  logic [7:0]  i2c_addr;
  logic [7:0]  i2c_wdata;
  logic        i2c_wr_en;
  logic        i2c_rd_done;
  logic [31:0] apb_rdata;
  logic [7:0]  i2c_rdata;
  logic [6:0]  dev_addr;
  logic        enable;
  logic [7:0]  debounce_len;
  logic [7:0]  scl_dly;
  logic [7:0]  sda_dly;
  logic        i2c_irq;
  logic        apb_irq;

  int          err_count;
  int          check_count;
  int          test_num;
  int          test_err_base;
  logic [31:0] rng_state;

  i2c_periph_top dut (
    .rst_i(rst), .clk_i(clk),
    .apb_waddr_i(apb_waddr), .apb_wdata_i(apb_wdata), .apb_wr_en_i(apb_wr_en),
    .apb_raddr_i(apb_raddr), .apb_rd_done_i(apb_rd_done),
    .i2c_addr_i(i2c_addr), .i2c_wdata_i(i2c_wdata), .i2c_wr_en_i(i2c_wr_en),
    .i2c_rd_done_i(i2c_rd_done),
    .apb_rdata_o(apb_rdata), .i2c_rdata_o(i2c_rdata),
    .dev_addr_o(dev_addr), .enable_o(enable), .debounce_len_o(debounce_len),
    .scl_dly_o(scl_dly), .sda_dly_o(sda_dly),
    .i2c_irq_o(i2c_irq), .apb_irq_o(apb_irq)
  );

  initial begin
    rst = 1'b0;
    forever #2 rst = ~rst;  // 4 ns period
  end

  initial begin
    #50000;
    $display("simulation ran past its time limit");
    $display("Testbench failed");
    $finish;
  end

  // read word is zero-extended
  a_rdata_upper_zero: assert property (@(posedge rst) disable iff (clk)
    apb_rdata[31:8] == 24'h0)
    else begin
      err_count++;
      $display("ERR %0t apb_rdata_o[31:8] expected 0x000000 actual 0x%06h", $time,
               apb_rdata[31:8]);
    end

  a_irq_known: assert property (@(posedge rst) disable iff (clk)
    !$isunknown({i2c_irq, apb_irq}))
    else begin
      err_count++;
      $display("an interrupt line went unknown at %0t", $time);
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  // read-side level code for a fill count
  function automatic logic [2:0] level_code(input int n);
    if (n == 0) return 3'd0;
    if (n == 1) return 3'd1;
    if (n <= 3) return 3'd2;
    if (n <= 7) return 3'd3;
    if (n <= 11) return 3'd4;
    if (n <= 14) return 3'd5;
    if (n == 15) return 3'd6;
    return 3'd7;
  endfunction

  function automatic logic [11:0] word_addr(input logic [7:0] idx);
    return {2'b00, idx, 2'b00};
  endfunction

  task automatic tick();
    @(posedge rst);
    #1;  // drive and sample just after the edge
  endtask

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("ERR %0t %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [7:0] data);
    apb_waddr = addr;
    apb_wdata = {24'hA5A5A5, data};  // upper bits are ignored by the DUT
    apb_wr_en = 1'b1;
    tick();
    apb_wr_en = 1'b0;
    tick();  // strobe reaches the FIFO or mailbox
  endtask

  task automatic apb_read(input logic [11:0] addr, input bit done, output logic [7:0] data);
    apb_raddr = addr;
    tick();
    data = apb_rdata[7:0];
    if (done) begin
      apb_rd_done = 1'b1;
      tick();
      apb_rd_done = 1'b0;
      tick();
    end
  endtask

  task automatic i2c_write(input logic [7:0] addr, input logic [7:0] data);
    i2c_addr  = addr;
    i2c_wdata = data;
    i2c_wr_en = 1'b1;
    tick();
    i2c_wr_en = 1'b0;
    tick();
  endtask

  task automatic i2c_read(input logic [7:0] addr, input bit done, output logic [7:0] data);
    i2c_addr = addr;  // shared with writes
    tick();
    data = i2c_rdata;
    if (done) begin
      i2c_rd_done = 1'b1;
      tick();
      i2c_rd_done = 1'b0;
      tick();
    end
  endtask

  task automatic expect_irq(input bit apb_side, input logic level);
    bit    seen;
    string name;
    seen = 1'b0;
    name = apb_side ? "apb_irq_o" : "i2c_irq_o";
    for (int i = 0; i < 4 && !seen; i++) begin
      if ((apb_side ? apb_irq : i2c_irq) === level)
        seen = 1'b1;
      else
        tick();
    end
    check_count++;
    assert (seen) else begin
      err_count++;
      $display("%s did not go to %0b within three cycles at %0t", name, level, $time);
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %s", test_num, name, (err_count == test_err_base) ? "ok" : "errors");
    test_err_base = err_count;
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] b;
    logic [7:0] cfg_exp [5];
    logic [7:0] q [$];
    clk           = 1'b1;
    apb_waddr     = '0;
    apb_wdata     = '0;
    apb_wr_en     = 1'b0;
    apb_raddr     = '0;
    apb_rd_done   = 1'b0;
    i2c_addr      = '0;
    i2c_wdata     = '0;
    i2c_wr_en     = 1'b0;
    i2c_rd_done   = 1'b0;
    err_count     = 0;
    check_count   = 0;
    test_num      = 0;
    test_err_base = 0;
    rng_state     = 32'd82;
    repeat (2) @(posedge rst);
    #1;
    clk = 1'b0;

    check_val("dev_addr_o", 8'h6F, {1'b0, dev_addr});
    check_val("enable_o", 8'h00, {7'b0, enable});
    check_val("debounce_len_o", 8'd20, debounce_len);
    check_val("scl_dly_o", 8'd20, scl_dly);
    check_val("sda_dly_o", 8'd8, sda_dly);
    check_val("i2c_irq_o", 8'h00, {7'b0, i2c_irq});
    check_val("apb_irq_o", 8'h00, {7'b0, apb_irq});
    check_val("apb_rdata_o", 8'h00, apb_rdata[7:0]);
    check_val("i2c_rdata_o", 8'h00, i2c_rdata);
    end_test("reset defaults");

    for (int i = 0; i < 5; i++) begin
      b = rand_byte();
      apb_write(word_addr(8'(i)), b);
      cfg_exp[i] = b;
    end
    cfg_exp[0][7] = 1'b0;                 // 7-bit device address
    cfg_exp[1]    = {7'b0, cfg_exp[1][0]}; // enable is a single bit
    check_val("dev_addr_o", cfg_exp[0], {1'b0, dev_addr});
    check_val("enable_o", cfg_exp[1], {7'b0, enable});
    check_val("debounce_len_o", cfg_exp[2], debounce_len);
    check_val("scl_dly_o", cfg_exp[3], scl_dly);
    check_val("sda_dly_o", cfg_exp[4], sda_dly);
    for (int i = 0; i < 5; i++) begin
      apb_read(word_addr(8'(i)), 1'b0, rd);
      check_val("apb_rdata_o", cfg_exp[i], rd);
      i2c_read(8'(i), 1'b0, rd);
      check_val("i2c_rdata_o", cfg_exp[i], rd);
    end
    apb_write(12'h400, ~cfg_exp[0]);  // outside the register window
    check_val("dev_addr_o", cfg_exp[0], {1'b0, dev_addr});
    apb_read(12'h800, 1'b0, rd);
    check_val("apb_rdata_o", 8'h00, rd);
    end_test("config registers");

    apb_write(word_addr(`REG_IRQ_APB_BASE + 8'd1), 8'h01);
    b = rand_byte();
    i2c_write(`REG_MSG_TOAPB, b);
    expect_irq(1'b1, 1'b1);
    i2c_read(`REG_MSG_TOAPB_ST, 1'b0, rd);
    check_val("msg_toapb_st", 8'h01, rd);
    apb_read(word_addr(`REG_MSG_TOAPB), 1'b1, rd);
    check_val("msg_toapb", b, rd);
    apb_read(word_addr(`REG_MSG_TOAPB_ST), 1'b0, rd);
    check_val("msg_toapb_st", 8'h00, rd);
    expect_irq(1'b1, 1'b0);
    i2c_write(`REG_IRQ_I2C_BASE + 8'd1, 8'h01);
    b = rand_byte();
    apb_write(word_addr(`REG_MSG_TOI2C), b);
    expect_irq(1'b0, 1'b1);
    apb_read(word_addr(`REG_MSG_TOI2C_ST), 1'b0, rd);
    check_val("msg_toi2c_st", 8'h01, rd);
    i2c_read(`REG_MSG_TOI2C, 1'b1, rd);
    check_val("msg_toi2c", b, rd);
    i2c_read(`REG_MSG_TOI2C_ST, 1'b0, rd);
    check_val("msg_toi2c_st", 8'h00, rd);
    expect_irq(1'b0, 1'b0);
    apb_write(word_addr(`REG_IRQ_APB_BASE + 8'd1), 8'h00);
    i2c_write(`REG_IRQ_I2C_BASE + 8'd1, 8'h00);
    end_test("mailboxes");

    for (int i = 0; i < 12; i++) begin
      b = rand_byte();
      q.push_back(b);
      i2c_write(`REG_FIFO_TOAPB_WR, b);
    end
    i2c_read(`REG_FIFO_TOAPB_WFLG, 1'b0, rd);
    check_val("fifo_toapb_wflg", {5'b0, 3'd7 - level_code(q.size())}, rd);
    while (q.size() > 0) begin
      apb_read(word_addr(`REG_FIFO_TOAPB_RFLG), 1'b0, rd);
      check_val("fifo_toapb_rflg", {5'b0, level_code(q.size())}, rd);
      apb_read(word_addr(`REG_FIFO_TOAPB_RD), 1'b1, rd);
      check_val("fifo_toapb_head", q.pop_front(), rd);
    end
    apb_read(word_addr(`REG_FIFO_TOAPB_RFLG), 1'b0, rd);
    check_val("fifo_toapb_rflg", 8'h00, rd);
    end_test("to-APB FIFO");

    i2c_write(`REG_IRQ_I2C_BASE + 8'd3, 8'h01);  // select b fires at code 0 only
    i2c_write(`REG_IRQ_I2C_BASE + 8'd1, 8'h02);
    for (int i = 0; i < 2; i++) begin
      b = rand_byte();
      q.push_back(b);
      apb_write(word_addr(`REG_FIFO_TOI2C_WR), b);
    end
    check_val("i2c_irq_o", 8'h00, {7'b0, i2c_irq});
    while (q.size() > 0) begin
      i2c_read(`REG_FIFO_TOI2C_RD, 1'b1, rd);
      check_val("fifo_toi2c_head", q.pop_front(), rd);
    end
    expect_irq(1'b0, 1'b1);
    i2c_write(`REG_IRQ_I2C_BASE + 8'd1, 8'h00);
    end_test("to-I2C FIFO interrupt");

    for (int i = 0; i < 17; i++) begin
      b = rand_byte();
      if (i < 16) q.push_back(b);  // last one must be dropped
      apb_write(word_addr(`REG_FIFO_TOI2C_WR), b);
    end
    apb_read(word_addr(`REG_FIFO_TOI2C_WFLG), 1'b0, rd);
    check_val("fifo_toi2c_wflg", 8'h00, rd);
    while (q.size() > 0) begin
      i2c_read(`REG_FIFO_TOI2C_RD, 1'b1, rd);
      check_val("fifo_toi2c_head", q.pop_front(), rd);
    end
    i2c_read(`REG_FIFO_TOI2C_RFLG, 1'b0, rd);
    check_val("fifo_toi2c_rflg", 8'h00, rd);
    end_test("FIFO overflow");

    $display("tests %0d, checks %0d, errors %0d", test_num, check_count, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/i2c_periph_pkg.sv
verilog/byte_fifo.sv
verilog/msg_mailbox.sv
verilog/irq_gen.sv
verilog/apb_reg_port.sv
verilog/i2c_reg_port.sv
verilog/i2c_periph_top.sv
verif/tb_i2c_periph.sv

//--- Makefile
# Verilator flow for the I2C peripheral bridge
TOP = tb_i2c_periph

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --assert --timescale 1ns/100ps -Wno-fatal -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
